// ==== hw/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int mem_depth   = 64,
    parameter int mem_latency = 3
) (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        mem_req_valid,
    output logic                       mem_req_ready,
    input  wire  dcache_pkg::mem_req_t mem_req,
    output logic                       mem_rsp_valid,
    output dcache_pkg::mem_rsp_t       mem_rsp
);

    localparam int addr_bits  = $clog2(mem_depth);
    localparam int count_bits = (mem_latency > 1) ? $clog2(mem_latency) : 1;
    localparam logic [count_bits-1:0] count_load = count_bits'(mem_latency - 1);

    dcache_pkg::word_t mem [mem_depth];
    dcache_pkg::mem_req_t req_q;
    logic busy;
    logic [count_bits-1:0] count;
    logic [addr_bits-1:0] mem_addr;

    initial begin
        $readmemh("mem_init.hex", mem);
    end

    // address wraps at the memory depth
    assign mem_addr      = req_q.addr[addr_bits-1:0];
    assign mem_req_ready = !busy;
    assign mem_rsp_valid = busy && (count == '0);
    assign mem_rsp.rdata = mem[mem_addr];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (!busy) begin
            if (mem_req_valid) begin
                busy  <= 1'b1;
                count <= count_load;
            end
        end else if (count == '0) begin
            busy <= 1'b0;
        end else begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req_valid && mem_req_ready) begin
            req_q <= mem_req;
        end
        // write lands as the response completes
        if (mem_rsp_valid && req_q.write) begin
            mem[mem_addr] <= req_q.wdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dcache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_array (
    input  wire                                  clk,
    input  wire                                  reset_n,
    input  wire  [dcache_pkg::index_size-1:0]    index,
    input  wire  [dcache_pkg::offset_size-1:0]   offset,
    input  wire  [dcache_pkg::tag_size-1:0]      tag,
    input  wire  dcache_pkg::word_t              wdata,
    input  wire                                  word_wr_en,
    input  wire                                  fill_wr_en,
    input  wire  [dcache_pkg::offset_size-1:0]   fill_offset,
    input  wire                                  line_set_en,
    output logic                                 lookup_valid,
    output logic [dcache_pkg::tag_size-1:0]      lookup_tag,
    output dcache_pkg::word_t                    lookup_word
);

    logic [dcache_pkg::num_sets-1:0] valid;
    logic [dcache_pkg::tag_size-1:0] tags [dcache_pkg::num_sets];
    dcache_pkg::word_t lines [dcache_pkg::num_sets][dcache_pkg::words_per_line];

    // reset invalidates every set
    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid <= '0;
        end else if (line_set_en) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_set_en) begin
            tags[index] <= tag;
        end
    end

    // processor word write or one word of a line fill
    always_ff @(posedge clk) begin
        if (word_wr_en) begin
            lines[index][offset] <= wdata;
        end else if (fill_wr_en) begin
            lines[index][fill_offset] <= wdata;
        end
    end

    // combinational lookup of the addressed set
    assign lookup_valid = valid[index];
    assign lookup_tag   = tags[index];
    assign lookup_word  = lines[index][offset];

    // the controller never mixes a processor write with a fill
    a_no_dual_write: assert property (
        @(posedge clk) disable iff (reset_n)
        !(word_wr_en && fill_wr_en)
    );

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int counter_width = 16
) (
    input  wire                                  clk,
    input  wire                                  reset_n,
    input  wire                                  cpu_req_valid,
    output logic                                 cpu_req_ready,
    input  wire  dcache_pkg::cpu_req_t           cpu_req,
    output logic                                 cpu_rsp_valid,
    output dcache_pkg::cpu_rsp_t                 cpu_rsp,
    input  wire                                  bus_grant,
    input  wire                                  lookup_valid,
    input  wire  [dcache_pkg::tag_size-1:0]      lookup_tag,
    input  wire  dcache_pkg::word_t              lookup_word,
    output logic                                 word_wr_en,
    output logic                                 fill_wr_en,
    output logic [dcache_pkg::offset_size-1:0]   fill_offset,
    output logic                                 line_set_en,
    output logic [dcache_pkg::index_size-1:0]    arr_index,
    output logic [dcache_pkg::offset_size-1:0]   arr_offset,
    output logic [dcache_pkg::tag_size-1:0]      arr_tag,
    output dcache_pkg::word_t                    arr_wdata,
    output logic                                 mem_req_valid,
    input  wire                                  mem_req_ready,
    output dcache_pkg::mem_req_t                 mem_req,
    input  wire                                  mem_rsp_valid,
    input  wire  dcache_pkg::mem_rsp_t           mem_rsp,
    output logic [counter_width-1:0]             hit_count,
    output logic [counter_width-1:0]             miss_count
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::cpu_req_t req_q;
    dcache_pkg::addr_fields_t req_fields;
    logic [dcache_pkg::offset_size-1:0] fill_cnt;
    logic hit;
    logic hit_q;
    logic mem_fire;

    assign req_fields = req_q.addr;
    assign hit        = lookup_valid && (lookup_tag == req_fields.tag);
    assign mem_fire   = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state      <= dcache_pkg::idle;
            fill_cnt   <= '0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            case (state)
                dcache_pkg::idle: begin
                    if (cpu_req_valid) begin
                        state <= dcache_pkg::lookup;
                    end
                end
                dcache_pkg::lookup: begin
                    if (req_q.write) begin
                        state <= dcache_pkg::write_req;
                    end else if (hit) begin
                        hit_count <= hit_count + 1'b1;
                        state     <= dcache_pkg::respond;
                    end else begin
                        miss_count <= miss_count + 1'b1;
                        fill_cnt   <= '0;
                        state      <= dcache_pkg::fill_req;
                    end
                end
                dcache_pkg::fill_req: begin
                    if (mem_fire) begin
                        state <= dcache_pkg::fill_wait;
                    end
                end
                dcache_pkg::fill_wait: begin
                    if (mem_rsp_valid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        // last word of the line ends the fill
                        state <= (&fill_cnt) ? dcache_pkg::respond : dcache_pkg::fill_req;
                    end
                end
                dcache_pkg::write_req: begin
                    if (mem_fire) begin
                        state <= dcache_pkg::write_wait;
                    end
                end
                dcache_pkg::write_wait: begin
                    if (mem_rsp_valid) begin
                        state <= dcache_pkg::respond;
                    end
                end
                default: begin
                    state <= dcache_pkg::idle;
                end
            endcase
        end
    end

    // request and hit flag held until the response
    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_req_ready) begin
            req_q <= cpu_req;
        end
        if (state == dcache_pkg::lookup) begin
            hit_q <= hit;
        end
    end

    assign cpu_req_ready = (state == dcache_pkg::idle);
    assign cpu_rsp_valid = (state == dcache_pkg::respond);
    assign cpu_rsp.rdata = lookup_word;
    assign cpu_rsp.hit   = hit_q;

    // array strobes
    assign word_wr_en  = (state == dcache_pkg::lookup) && req_q.write && hit;
    assign fill_wr_en  = (state == dcache_pkg::fill_wait) && mem_rsp_valid;
    assign line_set_en = fill_wr_en && (&fill_cnt);
    assign fill_offset = fill_cnt;
    assign arr_index   = req_fields.index;
    assign arr_offset  = req_fields.offset;
    assign arr_tag     = req_fields.tag;
    assign arr_wdata   = (state == dcache_pkg::fill_wait) ? mem_rsp.rdata : req_q.wdata;

    // memory requests only go out while the bus is granted
    assign mem_req_valid = bus_grant &&
                           ((state == dcache_pkg::fill_req) || (state == dcache_pkg::write_req));

    always_comb begin
        mem_req.write = (state == dcache_pkg::write_req);
        mem_req.wdata = req_q.wdata;
        if (state == dcache_pkg::fill_req) begin
            mem_req.addr = {req_fields.tag, req_fields.index, fill_cnt};
        end else begin
            mem_req.addr = req_q.addr;
        end
    end

    a_grant_gates_mem: assert property (
        @(posedge clk) disable iff (reset_n)
        mem_req_valid |-> bus_grant
    );

    a_ready_only_idle: assert property (
        @(posedge clk) disable iff (reset_n)
        (state != dcache_pkg::idle) |-> !cpu_req_ready
    );

endmodule

`default_nettype wire

// ==== hw/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int word_size      = 16;
    localparam int tag_size       = 12;
    localparam int index_size     = 2;
    localparam int offset_size    = 2;
    localparam int num_sets       = 4;
    localparam int words_per_line = 4;

    // addresses and data share one width
    typedef logic [word_size-1:0] word_t;

    // word address split into cache fields
    typedef struct packed {
        logic [tag_size-1:0]    tag;
        logic [index_size-1:0]  index;
        logic [offset_size-1:0] offset;
    } addr_fields_t;

    typedef struct packed {
        logic  write;
        word_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  hit;
    } cpu_rsp_t;

    typedef struct packed {
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        fill_req,
        fill_wait,
        write_req,
        write_wait,
        respond
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int mem_depth     = 64,
    parameter int mem_latency   = 3,
    parameter int counter_width = 16
) (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        cpu_req_valid,
    output logic                       cpu_req_ready,
    input  wire  dcache_pkg::cpu_req_t cpu_req,
    output logic                       cpu_rsp_valid,
    output dcache_pkg::cpu_rsp_t       cpu_rsp,
    input  wire                        bus_grant,
    output logic [counter_width-1:0]   hit_count,
    output logic [counter_width-1:0]   miss_count
);

    logic lookup_valid;
    logic [dcache_pkg::tag_size-1:0] lookup_tag;
    dcache_pkg::word_t lookup_word;
    logic word_wr_en;
    logic fill_wr_en;
    logic [dcache_pkg::offset_size-1:0] fill_offset;
    logic line_set_en;
    logic [dcache_pkg::index_size-1:0] arr_index;
    logic [dcache_pkg::offset_size-1:0] arr_offset;
    logic [dcache_pkg::tag_size-1:0] arr_tag;
    dcache_pkg::word_t arr_wdata;
    logic mem_req_valid;
    logic mem_req_ready;
    dcache_pkg::mem_req_t mem_req;
    logic mem_rsp_valid;
    dcache_pkg::mem_rsp_t mem_rsp;

    dcache_ctrl #(
        .counter_width (counter_width)
    ) dcache_ctrl_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req       (cpu_req),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp       (cpu_rsp),
        .bus_grant     (bus_grant),
        .lookup_valid  (lookup_valid),
        .lookup_tag    (lookup_tag),
        .lookup_word   (lookup_word),
        .word_wr_en    (word_wr_en),
        .fill_wr_en    (fill_wr_en),
        .fill_offset   (fill_offset),
        .line_set_en   (line_set_en),
        .arr_index     (arr_index),
        .arr_offset    (arr_offset),
        .arr_tag       (arr_tag),
        .arr_wdata     (arr_wdata),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

    dcache_array dcache_array_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .index        (arr_index),
        .offset       (arr_offset),
        .tag          (arr_tag),
        .wdata        (arr_wdata),
        .word_wr_en   (word_wr_en),
        .fill_wr_en   (fill_wr_en),
        .fill_offset  (fill_offset),
        .line_set_en  (line_set_en),
        .lookup_valid (lookup_valid),
        .lookup_tag   (lookup_tag),
        .lookup_word  (lookup_word)
    );

    // stands in for the rest of the memory system
    data_memory #(
        .mem_depth   (mem_depth),
        .mem_latency (mem_latency)
    ) data_memory_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== mem_init.hex ====
// data memory preload, one 16-bit hex word per line
// line n holds word address n, upper byte is n plus 0x10, lower byte is n
1000
1101
1202
1303
1404
1505
1606
1707
1808
1909
1A0A
1B0B
1C0C
1D0D
1E0E
1F0F
2010
2111
2212
2313
2414
2515
2616
2717
2818
2919
2A1A
2B1B
2C1C
2D1D
2E1E
2F1F
3020
3121
3222
3323
3424
3525
3626
3727
3828
3929
3A2A
3B2B
3C2C
3D2D
3E2E
3F2F
4030
4131
4232
4333
4434
4535
4636
4737
4838
4939
4A3A
4B3B
4C3C
4D3D
4E3E
4F3F

// ==== run.sh ====
#!/bin/sh
# build and run the dcache testbench, the log decides the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module dcache_tb \
    -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log \
    && { echo "simulation reported a failure"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== test/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int mem_depth         = 64;
    localparam int mem_latency       = 3;
    localparam int counter_width     = 16;
    localparam int clk_period        = 20;
    localparam int reset_cycles      = 8;
    localparam int grant_gap_bound   = 8;
    localparam int max_requests      = 100;
    // four fills, each waiting for grant, acceptance and the memory latency
    localparam int worst_miss_cycles = 4 * (mem_latency + 2 + grant_gap_bound) + 4;
    localparam int rsp_limit         = 4 * worst_miss_cycles;
    localparam int watchdog_cycles   = 2 * max_requests * worst_miss_cycles
                                       + 4 * reset_cycles + 40;

    logic clk;
    logic reset_n;
    logic cpu_req_valid;
    logic cpu_req_ready;
    dcache_pkg::cpu_req_t cpu_req;
    logic cpu_rsp_valid;
    dcache_pkg::cpu_rsp_t cpu_rsp;
    logic bus_grant;
    logic [counter_width-1:0] hit_count;
    logic [counter_width-1:0] miss_count;
    logic req_fire;

    // reference model of memory contents and cache tags
    dcache_pkg::word_t model_mem [mem_depth];
    logic model_valid [dcache_pkg::num_sets];
    logic [dcache_pkg::tag_size-1:0] model_tag [dcache_pkg::num_sets];
    int model_hits;
    int model_misses;

    // expectation for the request in flight
    dcache_pkg::word_t exp_rdata;
    logic exp_hit;
    logic exp_write;
    logic rsp_pending;
    logic grant_blocked;
    logic grant_random;
    logic grant_level;
    integer seed;
    int fail_count;
    int test_count;
    int failed_tests;

    assign req_fire = cpu_req_valid && cpu_req_ready;

    dcache_top dcache_top_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req       (cpu_req),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp       (cpu_rsp),
        .bus_grant     (bus_grant),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // bus grant is either held at a level or drawn each cycle
    initial begin : grant_driver
        logic [31:0] rnd;
        forever begin
            @(posedge clk);
            #2;
            if (grant_random) begin
                rnd = $random(seed);
                bus_grant = rnd[0];
            end else begin
                bus_grant = grant_level;
            end
        end
    end

    a_read_data: assert property (
        @(posedge clk) disable iff (reset_n)
        (cpu_rsp_valid && !exp_write) |-> (cpu_rsp.rdata == exp_rdata)
    ) else begin
        $display("[FAIL] %0t read data %h, expected %h", $time,
                 $sampled(cpu_rsp.rdata), $sampled(exp_rdata));
        fail_count = fail_count + 1;
    end

    a_hit_flag: assert property (
        @(posedge clk) disable iff (reset_n)
        cpu_rsp_valid |-> (cpu_rsp.hit == exp_hit)
    ) else begin
        $display("[FAIL] %0t hit flag %b, expected %b", $time,
                 $sampled(cpu_rsp.hit), $sampled(exp_hit));
        fail_count = fail_count + 1;
    end

    a_hit_latency: assert property (
        @(posedge clk) disable iff (reset_n)
        (cpu_rsp_valid && exp_hit && !exp_write) |-> $past(req_fire, 2)
    ) else begin
        $display("[FAIL] %0t read hit response not 2 cycles after the request", $time);
        fail_count = fail_count + 1;
    end

    a_counters: assert property (
        @(posedge clk) disable iff (reset_n)
        cpu_rsp_valid |-> (hit_count == counter_width'(model_hits)) &&
                          (miss_count == counter_width'(model_misses))
    ) else begin
        $display("[FAIL] %0t counters hit %0d miss %0d, expected hit %0d miss %0d", $time,
                 $sampled(hit_count), $sampled(miss_count), model_hits, model_misses);
        fail_count = fail_count + 1;
    end

    a_rsp_expected: assert property (
        @(posedge clk) disable iff (reset_n)
        cpu_rsp_valid |-> rsp_pending
    ) else begin
        $display("[FAIL] %0t response without a request in flight", $time);
        fail_count = fail_count + 1;
    end

    a_grant_blocked: assert property (
        @(posedge clk) disable iff (reset_n)
        grant_blocked |-> !cpu_rsp_valid
    ) else begin
        $display("[FAIL] %0t read miss answered while bus grant was low", $time);
        fail_count = fail_count + 1;
    end

    a_reset_state: assert property (
        @(posedge clk)
        $fell(reset_n) |-> (hit_count == '0) && (miss_count == '0) &&
                           cpu_req_ready && !cpu_rsp_valid
    ) else begin
        $display("[FAIL] %0t state after reset not cleared", $time);
        fail_count = fail_count + 1;
    end

    task automatic clear_tag_model();
        for (int s = 0; s < dcache_pkg::num_sets; s++) begin
            model_valid[s] = 1'b0;
            model_tag[s]   = '0;
        end
        model_hits   = 0;
        model_misses = 0;
    endtask

    // sets the expectation and advances the model for one access
    task automatic predict(input logic wr, input dcache_pkg::word_t addr,
                           input dcache_pkg::word_t wdata);
        dcache_pkg::addr_fields_t f;
        logic present;
        f = addr;
        present   = model_valid[f.index] && (model_tag[f.index] == f.tag);
        exp_write = wr;
        exp_hit   = present;
        exp_rdata = model_mem[int'(addr) % mem_depth];
        if (wr) begin
            model_mem[int'(addr) % mem_depth] = wdata;
        end else if (present) begin
            model_hits = model_hits + 1;
        end else begin
            model_misses = model_misses + 1;
            model_valid[f.index] = 1'b1;
            model_tag[f.index]   = f.tag;
        end
    endtask

    task automatic issue_request(input logic wr, input dcache_pkg::word_t addr,
                                 input dcache_pkg::word_t wdata);
        int waited;
        @(posedge clk);
        #2;
        predict(wr, addr, wdata);
        cpu_req.write = wr;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req_valid = 1'b1;
        rsp_pending   = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!cpu_req_ready && waited < rsp_limit) begin
            waited = waited + 1;
            @(negedge clk);
        end
        if (!cpu_req_ready) begin
            $display("%0t: request to address %h was never accepted", $time, addr);
            fail_count = fail_count + 1;
        end
        @(posedge clk);
        #2;
        cpu_req_valid = 1'b0;
    endtask

    task automatic wait_response(input dcache_pkg::word_t addr);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!cpu_rsp_valid && waited < rsp_limit) begin
            waited = waited + 1;
            @(negedge clk);
        end
        if (!cpu_rsp_valid) begin
            $display("%0t: no response for address %h within %0d cycles", $time, addr,
                     rsp_limit);
            fail_count = fail_count + 1;
        end
        // keep the expectation until the response edge has been sampled
        @(posedge clk);
        #2;
        rsp_pending = 1'b0;
    endtask

    task automatic access(input logic wr, input dcache_pkg::word_t addr,
                          input dcache_pkg::word_t wdata);
        issue_request(wr, addr, wdata);
        wait_response(addr);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        reset_n = 1'b1;
        clear_tag_model();
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset_n = 1'b0;
    endtask

    task automatic finish_test(input string name, input int fails_before);
        test_count = test_count + 1;
        if (fail_count == fails_before) begin
            $display("test %0s: ok", name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %0s: %0d errors", name, fail_count - fails_before);
        end
    endtask

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("simulation timed out after %0d cycles", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        int fails_before;
        logic [31:0] rnd;
        reset_n       = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        bus_grant     = 1'b0;
        grant_random  = 1'b0;
        grant_level   = 1'b1;
        grant_blocked = 1'b0;
        rsp_pending   = 1'b0;
        exp_rdata     = '0;
        exp_hit       = 1'b0;
        exp_write     = 1'b0;
        seed          = 32'h46f86de5;
        fail_count    = 0;
        test_count    = 0;
        failed_tests  = 0;
        $readmemh("mem_init.hex", model_mem);
        clear_tag_model();
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset_n = 1'b0;

        fails_before = fail_count;
        access(1'b0, 16'h0005, '0);
        access(1'b0, 16'h0005, '0);
        access(1'b0, 16'h0006, '0);
        access(1'b0, 16'h0004, '0);
        finish_test("read miss then hit", fails_before);

        fails_before = fail_count;
        access(1'b1, 16'h0006, 16'hbeef);
        access(1'b0, 16'h0006, '0);
        access(1'b1, 16'h0021, 16'h5a5a);
        access(1'b0, 16'h0021, '0);
        finish_test("write through", fails_before);

        // same index, tags 0 and 2
        fails_before = fail_count;
        for (int i = 0; i < 3; i++) begin
            access(1'b0, 16'h000a, '0);
            access(1'b0, 16'h002a, '0);
        end
        finish_test("conflict eviction", fails_before);

        fails_before = fail_count;
        for (int i = 0; i < 20; i++) begin
            access(1'b0, dcache_pkg::word_t'((i * 7) % 48), '0);
        end
        finish_test("counters", fails_before);

        // tag 3 has not been touched, so this read misses
        fails_before = fail_count;
        @(negedge clk);
        grant_level = 1'b0;
        issue_request(1'b0, 16'h0031, '0);
        grant_blocked = 1'b1;
        repeat (20) @(negedge clk);
        grant_blocked = 1'b0;
        grant_level   = 1'b1;
        wait_response(16'h0031);
        @(negedge clk);
        grant_random = 1'b1;
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            if (rnd[8:7] == 2'b00) begin
                access(1'b1, {10'd0, rnd[5:0]}, rnd[31:16]);
            end else begin
                access(1'b0, {10'd0, rnd[5:0]}, '0);
            end
        end
        @(negedge clk);
        grant_random = 1'b0;
        finish_test("bus grant", fails_before);

        fails_before = fail_count;
        apply_reset();
        access(1'b0, 16'h0005, '0);
        access(1'b0, 16'h0005, '0);
        access(1'b0, 16'h000a, '0);
        access(1'b0, 16'h0031, '0);
        finish_test("reset", fails_before);

        $display("summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
                 fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/dcache_pkg.sv
hw/dcache_array.sv
hw/dcache_ctrl.sv
hw/data_memory.sv
hw/dcache_top.sv
test/dcache_tb.sv
